// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP := cache_tb
FILE_LIST := build.f
OBJ_DIR := obj_dir
SIM := $(OBJ_DIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
hdl/cache_pkg.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/cache_controller.sv
hdl/cache_top.sv
dv/lower_memory.sv
dv/cache_tb.sv

// ==== dv/cache_tb.sv ====
// ----------------------------------------
// Cache testbench: clock, reset, tests read
// from a data file, value checks, watchdog
// ----------------------------------------
`default_nettype none

module cache_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int addr_width = cache_pkg::ADDR_WIDTH;
	localparam int word_width = cache_pkg::WORD_WIDTH;
	localparam int words_per_block = cache_pkg::WORDS_PER_BLOCK;
	localparam int num_sets = cache_pkg::NUM_SETS;
	localparam int num_ways = cache_pkg::NUM_WAYS;
	localparam int block_width = word_width * words_per_block;
	localparam int clk_period = 8;
	localparam int reset_cycles = 4;
	localparam int cycles_per_test = 60;
	localparam string test_file = "dv/cache_tests.txt";

	logic clk = 1'b0;
	logic reset;
	logic read;
	logic write;
	logic [addr_width-1:0] addr;
	logic [word_width-1:0] write_data;
	logic mem_ack;
	logic [block_width-1:0] mem_read_block;
	logic [word_width-1:0] read_data;
	logic done;
	logic hit;
	logic mem_read;
	logic mem_write;
	logic [addr_width-1:0] mem_addr;
	logic [block_width-1:0] mem_write_block;

	// One entry per test line
	string test_names[$];
	string test_ops[$];
	logic [addr_width-1:0] test_addrs[$];
	logic [word_width-1:0] test_wdata[$];
	logic [word_width-1:0] test_expected[$];
	logic test_hits[$];

	int error_count = 0;
	int check_count = 0;
	bit tests_loaded = 1'b0;

	always #(clk_period / 2) clk = ~clk;

	cache_top #(
		.addr_width(addr_width),
		.word_width(word_width),
		.words_per_block(words_per_block),
		.num_sets(num_sets),
		.num_ways(num_ways)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.read(read),
		.write(write),
		.addr(addr),
		.write_data(write_data),
		.mem_ack(mem_ack),
		.mem_read_block(mem_read_block),
		.read_data(read_data),
		.done(done),
		.hit(hit),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_write_block(mem_write_block)
	);

	lower_memory #(
		.addr_width(addr_width),
		.word_width(word_width),
		.words_per_block(words_per_block),
		.ack_delay(3)
	) u_memory (
		.clk(clk),
		.reset(reset),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_write_block(mem_write_block),
		.mem_ack(mem_ack),
		.mem_read_block(mem_read_block)
	);

	task automatic check_value(input string name, input string field,
			input logic [word_width-1:0] expected, input logic [word_width-1:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Fail %s %s: expected %h, actual %h", name, field, expected, actual);
		end
	endtask

	task automatic load_tests(output bit ok);
		int fd;
		int fields;
		string line;
		string name;
		string op;
		logic [31:0] a;
		logic [31:0] wd;
		logic [31:0] ex;
		logic [31:0] h;
		ok = 1'b0;
		fd = $fopen(test_file, "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) > 0 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%s %s %h %h %h %h", name, op, a, wd, ex, h);
					if (fields == 6) begin
						test_names.push_back(name);
						test_ops.push_back(op);
						test_addrs.push_back(a[addr_width-1:0]);
						test_wdata.push_back(wd[word_width-1:0]);
						test_expected.push_back(ex[word_width-1:0]);
						test_hits.push_back(h[0]);
					end
				end
			end
			$fclose(fd);
			ok = (test_names.size() > 0);
		end
	endtask

	// Nothing may move before the first request
	task automatic check_idle_after_reset();
		repeat (3) begin
			@(negedge clk);
			check_value("after_reset", "done", '0, word_width'(done));
			check_value("after_reset", "mem_read", '0, word_width'(mem_read));
			check_value("after_reset", "mem_write", '0, word_width'(mem_write));
		end
	endtask

	task automatic run_test(input int n);
		logic [word_width-1:0] got_data;
		logic got_hit;
		@(negedge clk);
		read = (test_ops[n] == "R");
		write = (test_ops[n] == "W");
		addr = test_addrs[n];
		write_data = test_wdata[n];
		@(negedge clk);
		while (!done)
			@(negedge clk);
		got_data = read_data;   // Stable in the middle of the done cycle
		got_hit = hit;
		@(negedge clk);
		read = 1'b0;
		write = 1'b0;
		if (test_ops[n] == "R")
			check_value(test_names[n], "read_data", test_expected[n], got_data);
		check_value(test_names[n], "hit", word_width'(test_hits[n]), word_width'(got_hit));
	endtask

	initial begin
		bit loaded;
		reset = 1'b1;
		read = 1'b0;
		write = 1'b0;
		addr = '0;
		write_data = '0;
		load_tests(loaded);
		tests_loaded = 1'b1;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
		if (!loaded) begin
			error_count++;
			$display("Could not read any test from %s", test_file);
		end else begin
			check_idle_after_reset();
			foreach (test_names[n])
				run_test(n);
		end
		repeat (2) @(negedge clk);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Budget grows with the number of test lines
	initial begin
		wait (tests_loaded);
		repeat ((test_names.size() + 1) * cycles_per_test + reset_cycles) @(posedge clk);
		$display("Timeout: the cache did not finish the tests in time");
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/cache_tests.txt ====
# name  op (R or W)  address  write data  expected read data  expected hit
# Numbers are hex and the expected read data is unused for writes
cold_read        R 0010 00000000 00001030 0
same_block_a     R 0014 00000000 0000103c 1
same_block_b     R 0010 00000000 00001030 1
write_hit        W 0018 a5a50018 00000000 1
read_written     R 0018 00000000 a5a50018 1
other_word_hi    R 001c 00000000 00001054 1
other_word_lo    R 0014 00000000 0000103c 1
fill_a           R 0000 00000000 00001000 0
fill_b           R 0080 00000000 00001180 0
fill_c           R 0100 00000000 00001300 0
fill_d           R 0180 00000000 00001480 0
touch_a          R 0004 00000000 0000100c 1
fill_e_evict_b   R 0200 00000000 00001600 0
a_kept           R 0004 00000000 0000100c 1
b_evicted        R 0080 00000000 00001180 0
c_evicted        R 0100 00000000 00001300 0
a_still_kept     R 0008 00000000 00001018 1
dirty_b          W 0084 dead0084 00000000 1
dirty_e          W 0208 beef0208 00000000 1
fill_f           R 0280 00000000 00001780 0
fill_g           R 0300 00000000 00001900 0
wb_b_fill_h      R 0380 00000000 00001a80 0
wb_e_fill_i      R 0400 00000000 00001c00 0
reread_b         R 0084 00000000 dead0084 0
b_other_word     R 0080 00000000 00001180 1
reread_e         R 0208 00000000 beef0208 0
e_other_word     R 020c 00000000 00001624 1
write_miss       W 0094 12340094 00000000 0
read_write_miss  R 0094 00000000 12340094 1
write_miss_other R 0090 00000000 000011b0 1

// ==== dv/lower_memory.sv ====
// ----------------------------------------
// Behavioral lower-level block memory with
// a fixed ack delay and rule-based contents
// ----------------------------------------
`default_nettype none

module lower_memory #(
	parameter int addr_width = cache_pkg::ADDR_WIDTH,
	parameter int word_width = cache_pkg::WORD_WIDTH,
	parameter int words_per_block = cache_pkg::WORDS_PER_BLOCK,
	parameter int ack_delay = 3
) (
	input  logic clk,
	input  logic reset,
	input  logic mem_read,
	input  logic mem_write,
	input  logic [addr_width-1:0] mem_addr,
	input  logic [word_width*words_per_block-1:0] mem_write_block,
	output logic mem_ack,
	output logic [word_width*words_per_block-1:0] mem_read_block
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int byte_bits = $clog2(word_width / 8);
	localparam int num_words = 2 ** (addr_width - byte_bits);

	logic [word_width-1:0] words [num_words];

	// Outputs change only on falling edges
	initial begin
		int wait_count;
		int base;
		mem_ack = 1'b0;
		mem_read_block = '0;
		wait_count = 0;
		for (int i = 0; i < num_words; i++)
			words[i] = word_width'(i * (word_width / 8) * 3 + 'h1000);   // Byte address times 3
		forever begin
			@(negedge clk);
			base = int'(mem_addr[addr_width-1:byte_bits]);
			if (reset || mem_ack) begin
				mem_ack = 1'b0;   // Ack lasts one cycle
				wait_count = 0;
			end else if (mem_read || mem_write) begin
				if (wait_count == ack_delay - 1) begin
					for (int w = 0; w < words_per_block; w++) begin
						if (mem_write)
							words[base + w] = mem_write_block[w*word_width +: word_width];
						else
							mem_read_block[w*word_width +: word_width] = words[base + w];
					end
					mem_ack = 1'b1;
					wait_count = 0;
				end else begin
					wait_count++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cache_controller.sv ====
// ----------------------------------------
// IDLE/COMPARE/WRITE_BACK/ALLOCATE FSM,
// store update strobes and memory requests
// ----------------------------------------
`default_nettype none

module cache_controller #(
	parameter int addr_width = cache_pkg::ADDR_WIDTH,
	parameter int word_width = cache_pkg::WORD_WIDTH,
	parameter int words_per_block = cache_pkg::WORDS_PER_BLOCK,
	parameter int num_sets = cache_pkg::NUM_SETS,
	parameter int num_ways = cache_pkg::NUM_WAYS
) (
	input  logic clk,
	input  logic reset,
	input  logic read,
	input  logic write,
	input  logic [addr_width-1:0] addr,
	input  logic hit_in,
	input  logic [$clog2(num_ways)-1:0] hit_way,
	input  logic [$clog2(num_ways)-1:0] victim_way,
	input  logic victim_dirty,
	input  logic [addr_width-$clog2(num_sets)-$clog2(words_per_block)-$clog2(word_width/8)-1:0] victim_tag,
	input  logic mem_ack,
	output logic touch,
	output logic set_dirty,
	output logic clear_dirty,
	output logic fill,
	output logic write_word,
	output logic [$clog2(num_ways)-1:0] way_sel,
	output logic done,
	output logic hit,
	output logic mem_read,
	output logic mem_write,
	output logic [addr_width-1:0] mem_addr
);

	localparam int offset_width = $clog2(words_per_block) + $clog2(word_width / 8);
	localparam int index_width = $clog2(num_sets);
	localparam int tag_width = addr_width - index_width - offset_width;

	cache_pkg::ctrl_state_t state, next_state;

	logic missed;   // Set once this transaction has missed
	logic [index_width-1:0] index;
	logic [tag_width-1:0] tag;
	logic lookup_hit;

	assign index = addr[offset_width +: index_width];
	assign tag = addr[addr_width-1 -: tag_width];

	assign lookup_hit = (state == cache_pkg::COMPARE) && hit_in;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= cache_pkg::IDLE;
			missed <= 1'b0;
		end else begin
			state <= next_state;
			if (state == cache_pkg::COMPARE)
				missed <= !hit_in;   // Cleared again when the transaction completes
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			cache_pkg::IDLE: begin
				if (read || write)
					next_state = cache_pkg::COMPARE;
			end
			cache_pkg::COMPARE: begin
				if (hit_in)
					next_state = cache_pkg::IDLE;
				else if (victim_dirty)
					next_state = cache_pkg::WRITE_BACK;
				else
					next_state = cache_pkg::ALLOCATE;
			end
			cache_pkg::WRITE_BACK: begin
				if (mem_ack)
					next_state = cache_pkg::ALLOCATE;
			end
			cache_pkg::ALLOCATE: begin
				if (mem_ack)
					next_state = cache_pkg::COMPARE;   // Second look now hits
			end
			default: next_state = cache_pkg::IDLE;
		endcase
	end

	// Store strobes
	assign touch = lookup_hit;
	assign set_dirty = lookup_hit && write;
	assign write_word = lookup_hit && write;
	assign clear_dirty = (state == cache_pkg::WRITE_BACK) && mem_ack;
	assign fill = (state == cache_pkg::ALLOCATE) && mem_ack;

	// Hit way on lookup, victim way while replacing
	assign way_sel = (state == cache_pkg::COMPARE) ? hit_way : victim_way;

	// Requester side
	assign done = lookup_hit;
	assign hit = lookup_hit && !missed;

	// Lower memory requests drop as soon as the ack shows up
	assign mem_write = (state == cache_pkg::WRITE_BACK) && !mem_ack;
	assign mem_read = (state == cache_pkg::ALLOCATE) && !mem_ack;

	always_comb begin
		if (state == cache_pkg::WRITE_BACK)
			mem_addr = {victim_tag, index, {offset_width{1'b0}}};
		else
			mem_addr = {tag, index, {offset_width{1'b0}}};
	end

	// Lower memory answers only an open request
	a_ack_on_request: assert property (@(posedge clk) disable iff (reset)
		mem_ack |-> (state == cache_pkg::WRITE_BACK || state == cache_pkg::ALLOCATE));

	// Requester holds its request up to done
	a_request_held: assert property (@(posedge clk) disable iff (reset)
		done |-> (read || write));

endmodule

`default_nettype wire

// ==== hdl/cache_pkg.sv ====
// ----------------------------------------
// Default cache geometry constants and the
// cache controller state encoding
// ----------------------------------------
`default_nettype none

package cache_pkg;

	// Byte address and data word widths
	parameter int ADDR_WIDTH = 16;
	parameter int WORD_WIDTH = 32;

	// Block and set organization
	parameter int WORDS_PER_BLOCK = 4;   // 128-bit block
	parameter int NUM_SETS = 8;
	parameter int NUM_WAYS = 4;

	// Controller states
	typedef enum logic [1:0] {
		IDLE,
		COMPARE,
		WRITE_BACK,
		ALLOCATE
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== hdl/cache_top.sv ====
// ----------------------------------------
// Cache top level: address split and the
// tag store, data store and controller
// ----------------------------------------
`default_nettype none

module cache_top #(
	parameter int addr_width = cache_pkg::ADDR_WIDTH,
	parameter int word_width = cache_pkg::WORD_WIDTH,
	parameter int words_per_block = cache_pkg::WORDS_PER_BLOCK,
	parameter int num_sets = cache_pkg::NUM_SETS,
	parameter int num_ways = cache_pkg::NUM_WAYS
) (
	input  logic clk,
	input  logic reset,
	input  logic read,
	input  logic write,
	input  logic [addr_width-1:0] addr,
	input  logic [word_width-1:0] write_data,
	input  logic mem_ack,
	input  logic [word_width*words_per_block-1:0] mem_read_block,
	output logic [word_width-1:0] read_data,
	output logic done,
	output logic hit,
	output logic mem_read,
	output logic mem_write,
	output logic [addr_width-1:0] mem_addr,
	output logic [word_width*words_per_block-1:0] mem_write_block
);

	localparam int byte_bits = $clog2(word_width / 8);
	localparam int word_sel_width = $clog2(words_per_block);
	localparam int offset_width = word_sel_width + byte_bits;
	localparam int index_width = $clog2(num_sets);
	localparam int tag_width = addr_width - index_width - offset_width;
	localparam int way_width = $clog2(num_ways);

	logic [tag_width-1:0] tag;
	logic [index_width-1:0] index;
	logic [word_sel_width-1:0] word_sel;

	logic hit_in;
	logic [way_width-1:0] hit_way;
	logic [way_width-1:0] victim_way;
	logic victim_dirty;
	logic [tag_width-1:0] victim_tag;
	logic touch;
	logic set_dirty;
	logic clear_dirty;
	logic fill;
	logic write_word;
	logic [way_width-1:0] way_sel;

	// Address split
	assign tag = addr[addr_width-1 -: tag_width];
	assign index = addr[offset_width +: index_width];
	assign word_sel = addr[byte_bits +: word_sel_width];   // Byte bits ignored

	tag_store #(
		.addr_width(addr_width),
		.word_width(word_width),
		.words_per_block(words_per_block),
		.num_sets(num_sets),
		.num_ways(num_ways)
	) u_tag_store (
		.clk(clk),
		.reset(reset),
		.index(index),
		.tag(tag),
		.touch(touch),
		.touch_way(way_sel),
		.set_dirty(set_dirty),
		.clear_dirty(clear_dirty),
		.fill(fill),
		.fill_way(way_sel),
		.hit(hit_in),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag)
	);

	data_store #(
		.addr_width(addr_width),
		.word_width(word_width),
		.words_per_block(words_per_block),
		.num_sets(num_sets),
		.num_ways(num_ways)
	) u_data_store (
		.clk(clk),
		.reset(reset),
		.index(index),
		.word_sel(word_sel),
		.way(way_sel),
		.write_word(write_word),
		.write_data(write_data),
		.fill(fill),
		.fill_block(mem_read_block),
		.read_word(read_data),
		.read_block(mem_write_block)   // Victim block during write-back
	);

	cache_controller #(
		.addr_width(addr_width),
		.word_width(word_width),
		.words_per_block(words_per_block),
		.num_sets(num_sets),
		.num_ways(num_ways)
	) u_controller (
		.clk(clk),
		.reset(reset),
		.read(read),
		.write(write),
		.addr(addr),
		.hit_in(hit_in),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.mem_ack(mem_ack),
		.touch(touch),
		.set_dirty(set_dirty),
		.clear_dirty(clear_dirty),
		.fill(fill),
		.write_word(write_word),
		.way_sel(way_sel),
		.done(done),
		.hit(hit),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_addr(mem_addr)
	);

endmodule

`default_nettype wire

// ==== hdl/data_store.sv ====
// ----------------------------------------
// Block data array with word write, word
// read, block read and block fill
// ----------------------------------------
`default_nettype none

module data_store #(
	parameter int addr_width = cache_pkg::ADDR_WIDTH,
	parameter int word_width = cache_pkg::WORD_WIDTH,
	parameter int words_per_block = cache_pkg::WORDS_PER_BLOCK,
	parameter int num_sets = cache_pkg::NUM_SETS,
	parameter int num_ways = cache_pkg::NUM_WAYS
) (
	input  logic clk,
	input  logic reset,
	input  logic [$clog2(num_sets)-1:0] index,
	input  logic [$clog2(words_per_block)-1:0] word_sel,
	input  logic [$clog2(num_ways)-1:0] way,
	input  logic write_word,
	input  logic [word_width-1:0] write_data,
	input  logic fill,
	input  logic [word_width*words_per_block-1:0] fill_block,
	output logic [word_width-1:0] read_word,
	output logic [word_width*words_per_block-1:0] read_block
);

	localparam int block_width = word_width * words_per_block;
	localparam int offset_width = $clog2(words_per_block) + $clog2(word_width / 8);
	localparam int index_width = $clog2(num_sets);

	// Index plus offset can never exceed the address
	initial begin
		assert (index_width + offset_width < addr_width)
		else $error("Address too narrow for the cache geometry");
	end

	logic [block_width-1:0] blocks [num_sets][num_ways];

	always_ff @(posedge clk) begin
		if (fill)
			blocks[index][way] <= fill_block;   // Whole block from lower memory
		else if (write_word)
			blocks[index][way][word_sel*word_width +: word_width] <= write_data;
	end

	// Zero-cycle lookups
	always_comb begin
		read_block = blocks[index][way];
		read_word = read_block[word_sel*word_width +: word_width];
	end

	a_write_or_fill: assert property (@(posedge clk) disable iff (reset) !(write_word && fill));

endmodule

`default_nettype wire

// ==== hdl/tag_store.sv ====
// ----------------------------------------
// Tag, valid, dirty and LRU rank arrays
// with hit detection and victim selection
// ----------------------------------------
`default_nettype none

module tag_store #(
	parameter int addr_width = cache_pkg::ADDR_WIDTH,
	parameter int word_width = cache_pkg::WORD_WIDTH,
	parameter int words_per_block = cache_pkg::WORDS_PER_BLOCK,
	parameter int num_sets = cache_pkg::NUM_SETS,
	parameter int num_ways = cache_pkg::NUM_WAYS
) (
	input  logic clk,
	input  logic reset,
	input  logic [$clog2(num_sets)-1:0] index,
	input  logic [addr_width-$clog2(num_sets)-$clog2(words_per_block)-$clog2(word_width/8)-1:0] tag,
	input  logic touch,
	input  logic [$clog2(num_ways)-1:0] touch_way,
	input  logic set_dirty,
	input  logic clear_dirty,
	input  logic fill,
	input  logic [$clog2(num_ways)-1:0] fill_way,
	output logic hit,
	output logic [$clog2(num_ways)-1:0] hit_way,
	output logic [$clog2(num_ways)-1:0] victim_way,
	output logic victim_dirty,
	output logic [addr_width-$clog2(num_sets)-$clog2(words_per_block)-$clog2(word_width/8)-1:0] victim_tag
);

	localparam int offset_width = $clog2(words_per_block) + $clog2(word_width / 8);
	localparam int index_width = $clog2(num_sets);
	localparam int tag_width = addr_width - index_width - offset_width;
	localparam int way_width = $clog2(num_ways);
	localparam int rank_width = $clog2(num_ways);
	localparam logic [rank_width-1:0] top_rank = rank_width'(num_ways - 1);

	logic [tag_width-1:0] tags [num_sets][num_ways];
	logic [num_ways-1:0] valid [num_sets];
	logic [num_ways-1:0] dirty [num_sets];
	logic [rank_width-1:0] lru [num_sets][num_ways];   // 0 is least recently used

	logic [num_ways-1:0] hit_vec;

	// Tag compare across all ways of the set
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < num_ways; w++) begin
			hit_vec[w] = valid[index][w] && (tags[index][w] == tag);
			if (hit_vec[w])
				hit_way = way_width'(w);
		end
		hit = |hit_vec;
	end

	// Lowest invalid way wins, else the rank 0 way
	always_comb begin
		victim_way = '0;
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (lru[index][w] == '0)
				victim_way = way_width'(w);
		end
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (!valid[index][w])
				victim_way = way_width'(w);
		end
		victim_dirty = dirty[index][victim_way];
		victim_tag = tags[index][victim_way];   // Rebuilds the write-back address
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < num_sets; s++) begin
				valid[s] <= '0;
				dirty[s] <= '0;
				for (int w = 0; w < num_ways; w++)
					lru[s][w] <= '0;
			end
		end else begin
			if (touch) begin
				// Ways above the old rank move down one step
				for (int w = 0; w < num_ways; w++) begin
					if (lru[index][w] > lru[index][touch_way])
						lru[index][w] <= lru[index][w] - 1'b1;
				end
				lru[index][touch_way] <= top_rank;
			end
			if (set_dirty)
				dirty[index][touch_way] <= 1'b1;
			if (clear_dirty)
				dirty[index][touch_way] <= 1'b0;   // Victim has been written back
			if (fill) begin
				valid[index][fill_way] <= 1'b1;
				dirty[index][fill_way] <= 1'b0;
			end
		end
	end

	// Tag written with each fill
	always_ff @(posedge clk) begin
		if (fill)
			tags[index][fill_way] <= tag;
	end

	a_one_hit: assert property (@(posedge clk) disable iff (reset) $onehot0(hit_vec));

	// A freshly filled block is clean until a later write hit
	a_fill_clean: assert property (@(posedge clk) disable iff (reset) !(fill && set_dirty));

endmodule

`default_nettype wire
